/* logic/sonata_cfg.svh */
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem configuration
// Bus widths, device windows and register offsets
////////////////////////////////////////////////////////////////////////////
`ifndef SONATA_CFG_SVH
`define SONATA_CFG_SVH

`define SONATA_BUS_ADDR_W  32
`define SONATA_BUS_DATA_W  32
`define SONATA_BUS_BE_W    4
`define SONATA_DEV_OFFS_W  12   // Offset inside a 4 KiB window

`define SONATA_GPI_W       13
`define SONATA_GPO_W       24
`define SONATA_PWM_W       12   // PWM channel count
`define SONATA_PWM_CTR_W   8

`define SONATA_GPIO_BASE   32'h8000_0000
`define SONATA_PWM_BASE    32'h8000_1000
`define SONATA_TIMER_BASE  32'h8000_2000

// Register offsets inside each window
`define SONATA_GPIO_OUT_OFFS         12'h000
`define SONATA_GPIO_IN_OFFS          12'h004
`define SONATA_PWM_PERIOD_OFFS       12'h000
`define SONATA_PWM_DUTY_OFFS         12'h004   // First duty, one word per channel
`define SONATA_TIMER_MTIME_LO_OFFS    12'h000
`define SONATA_TIMER_MTIME_HI_OFFS    12'h004
`define SONATA_TIMER_MTIMECMP_LO_OFFS 12'h008
`define SONATA_TIMER_MTIMECMP_HI_OFFS 12'h00C

`endif

/* logic/bus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Register bus types
// Address, data, byte enables, operation and device select
////////////////////////////////////////////////////////////////////////////
`include "sonata_cfg.svh"

package bus_pkg;

  typedef logic [`SONATA_BUS_ADDR_W-1:0] addr_t;
  typedef logic [`SONATA_BUS_DATA_W-1:0] data_t;
  typedef logic [`SONATA_BUS_BE_W-1:0]   be_t;
  typedef logic [`SONATA_DEV_OFFS_W-1:0] offs_t;   // Offset inside a device window

  // Host operation
  typedef enum logic {
    OP_READ,
    OP_WRITE
  } bus_op_e;

  // Target of a decoded request
  typedef enum logic [1:0] {
    DEV_GPIO,
    DEV_PWM,
    DEV_TIMER,
    DEV_NONE   // Unmapped, answered with an error
  } dev_sel_e;

endpackage

/* logic/periph_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral register types
// Pin vectors, PWM counter width and timer register map
////////////////////////////////////////////////////////////////////////////
`include "sonata_cfg.svh"

package periph_pkg;

  typedef logic [`SONATA_GPI_W-1:0]     gpi_t;
  typedef logic [`SONATA_GPO_W-1:0]     gpo_t;
  typedef logic [`SONATA_PWM_W-1:0]     pwm_t;
  typedef logic [`SONATA_PWM_CTR_W-1:0] pwm_ctr_t;

  // Machine time and compare
  typedef logic [63:0] time_t;

  // Timer registers, value equals offset bits 3..2
  typedef enum logic [1:0] {
    TMR_MTIME_LO,
    TMR_MTIME_HI,
    TMR_MTIMECMP_LO,
    TMR_MTIMECMP_HI
  } timer_reg_e;

endpackage

/* logic/bus_xbar.sv */
////////////////////////////////////////////////////////////////////////////
// Register bus decoder
// Routes each request to one device and muxes the response back
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sonata_cfg.svh"

module bus_xbar (
  input  logic              clk_sys_i,
  input  logic              rst_i,
  // Host side
  input  logic              req_i,
  input  bus_pkg::bus_op_e  op_i,
  input  bus_pkg::addr_t    addr_i,
  input  bus_pkg::be_t      be_i,
  input  bus_pkg::data_t    wdata_i,
  output logic              rvalid_o,
  output bus_pkg::data_t    rdata_o,
  output logic              err_o,
  // Device side
  output logic              gpio_req_o,
  output logic              pwm_req_o,
  output logic              timer_req_o,
  output bus_pkg::bus_op_e  dev_op_o,
  output bus_pkg::offs_t    dev_offs_o,
  output bus_pkg::be_t      dev_be_o,
  output bus_pkg::data_t    dev_wdata_o,
  input  logic              gpio_rvalid_i,
  input  bus_pkg::data_t    gpio_rdata_i,
  input  logic              pwm_rvalid_i,
  input  bus_pkg::data_t    pwm_rdata_i,
  input  logic              timer_rvalid_i,
  input  bus_pkg::data_t    timer_rdata_i
);

  bus_pkg::addr_t    addr_win;
  bus_pkg::dev_sel_e sel_d;
  bus_pkg::dev_sel_e sel_q;
  bus_pkg::bus_op_e  op_q;
  logic              req_q;
  bus_pkg::data_t    rdata_mux;

  ////////////////////////////////////////////////////////////////////////////
  // Decode

  // Window base of the request address
  assign addr_win = {addr_i[`SONATA_BUS_ADDR_W-1:`SONATA_DEV_OFFS_W],
                     {`SONATA_DEV_OFFS_W{1'b0}}};

  always_comb begin
    if (addr_win == `SONATA_GPIO_BASE) sel_d = bus_pkg::DEV_GPIO;
    else if (addr_win == `SONATA_PWM_BASE) sel_d = bus_pkg::DEV_PWM;
    else if (addr_win == `SONATA_TIMER_BASE) sel_d = bus_pkg::DEV_TIMER;
    else sel_d = bus_pkg::DEV_NONE;
  end

  assign gpio_req_o  = req_i && (sel_d == bus_pkg::DEV_GPIO);
  assign pwm_req_o   = req_i && (sel_d == bus_pkg::DEV_PWM);
  assign timer_req_o = req_i && (sel_d == bus_pkg::DEV_TIMER);

  assign dev_op_o    = op_i;
  assign dev_offs_o  = addr_i[`SONATA_DEV_OFFS_W-1:0];
  assign dev_be_o    = be_i;
  assign dev_wdata_o = wdata_i;

  // Select and op for the response cycle
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      req_q <= 1'b0;
      sel_q <= bus_pkg::DEV_NONE;
      op_q  <= bus_pkg::OP_READ;
    end else begin
      req_q <= req_i;
      sel_q <= sel_d;
      op_q  <= op_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response mux

  always_comb begin
    rvalid_o  = 1'b0;
    err_o     = 1'b0;
    rdata_mux = '0;
    case (sel_q)
      bus_pkg::DEV_GPIO: begin
        rvalid_o  = gpio_rvalid_i;
        rdata_mux = gpio_rdata_i;
      end
      bus_pkg::DEV_PWM: begin
        rvalid_o  = pwm_rvalid_i;
        rdata_mux = pwm_rdata_i;
      end
      bus_pkg::DEV_TIMER: begin
        rvalid_o  = timer_rvalid_i;
        rdata_mux = timer_rdata_i;
      end
      default: begin
        rvalid_o = req_q;   // Error answered here
        err_o    = req_q;
      end
    endcase
  end

  // Writes and errors return zero data
  assign rdata_o = (rvalid_o && op_q == bus_pkg::OP_READ) ? rdata_mux : '0;

endmodule

/* logic/gpio_regs.sv */
////////////////////////////////////////////////////////////////////////////
// GPIO register block
// Byte-writable outputs and two-flop synchronised inputs
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sonata_cfg.svh"

module gpio_regs (
  input  logic              clk_sys_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  bus_pkg::bus_op_e  op_i,
  input  bus_pkg::offs_t    offs_i,
  input  bus_pkg::be_t      be_i,
  input  bus_pkg::data_t    wdata_i,
  input  periph_pkg::gpi_t  gp_i,
  output logic              rvalid_o,
  output bus_pkg::data_t    rdata_o,
  output periph_pkg::gpo_t  gp_o
);

  periph_pkg::gpi_t gpi_meta_q;
  periph_pkg::gpi_t gpi_sync_q;
  periph_pkg::gpo_t gpo_q;
  bus_pkg::data_t   rdata_d;
  logic             wr_en;
  logic             rd_en;

  assign wr_en = req_i && op_i == bus_pkg::OP_WRITE && offs_i == `SONATA_GPIO_OUT_OFFS;
  assign rd_en = req_i && op_i == bus_pkg::OP_READ;

  // Input synchroniser
  always_ff @(posedge clk_sys_i) begin
    gpi_meta_q <= gp_i;
    gpi_sync_q <= gpi_meta_q;
  end

  // Output register, one lane per enabled byte
  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      gpo_q <= '0;
    end else if (wr_en) begin
      for (int b = 0; b < `SONATA_GPO_W / 8; b++) begin
        if (be_i[b]) gpo_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  always_comb begin
    case (offs_i)
      `SONATA_GPIO_OUT_OFFS: rdata_d = bus_pkg::data_t'(gpo_q);
      `SONATA_GPIO_IN_OFFS:  rdata_d = bus_pkg::data_t'(gpi_sync_q);
      default:               rdata_d = '0;   // Unknown offset reads zero
    endcase
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) rvalid_o <= 1'b0;
    else       rvalid_o <= req_i;
  end

  always_ff @(posedge clk_sys_i) begin
    if (rd_en) rdata_o <= rdata_d;
  end

  assign gp_o = gpo_q;

endmodule

/* logic/pwm_regs.sv */
////////////////////////////////////////////////////////////////////////////
// PWM register block
// Shared wrapping period counter and one duty compare per channel
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sonata_cfg.svh"

module pwm_regs (
  input  logic              clk_sys_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  bus_pkg::bus_op_e  op_i,
  input  bus_pkg::offs_t    offs_i,
  input  bus_pkg::be_t      be_i,
  input  bus_pkg::data_t    wdata_i,
  output logic              rvalid_o,
  output bus_pkg::data_t    rdata_o,
  output periph_pkg::pwm_t  pwm_o
);

  periph_pkg::pwm_ctr_t           period_q;
  periph_pkg::pwm_ctr_t           ctr_q;
  periph_pkg::pwm_ctr_t           duty_q [`SONATA_PWM_W];
  bus_pkg::offs_t                 duty_offs;
  logic [`SONATA_DEV_OFFS_W-3:0]  duty_idx;   // Word index from first duty
  logic                           duty_hit;
  logic                           wr_en;
  bus_pkg::data_t                 rdata_d;

  assign wr_en     = req_i && op_i == bus_pkg::OP_WRITE && be_i[0];
  assign duty_offs = offs_i - `SONATA_PWM_DUTY_OFFS;
  assign duty_idx  = duty_offs[`SONATA_DEV_OFFS_W-1:2];
  assign duty_hit  = offs_i >= `SONATA_PWM_DUTY_OFFS && offs_i[1:0] == 2'b00 &&
                     duty_idx < `SONATA_PWM_W;

  ////////////////////////////////////////////////////////////////////////////
  // Registers and counter

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      period_q <= '1;
      ctr_q    <= '0;
      for (int c = 0; c < `SONATA_PWM_W; c++) duty_q[c] <= '0;
    end else begin
      ctr_q <= (ctr_q >= period_q) ? '0 : ctr_q + 1'b1;   // period+1 clocks per cycle
      if (wr_en && offs_i == `SONATA_PWM_PERIOD_OFFS) begin
        period_q <= wdata_i[`SONATA_PWM_CTR_W-1:0];
      end
      for (int c = 0; c < `SONATA_PWM_W; c++) begin
        if (wr_en && duty_hit && duty_idx == (`SONATA_DEV_OFFS_W-2)'(c)) begin
          duty_q[c] <= wdata_i[`SONATA_PWM_CTR_W-1:0];
        end
      end
    end
  end

  // High while the counter is below duty
  always_comb begin
    for (int c = 0; c < `SONATA_PWM_W; c++) pwm_o[c] = ctr_q < duty_q[c];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read back

  always_comb begin
    rdata_d = '0;
    if (offs_i == `SONATA_PWM_PERIOD_OFFS) rdata_d = bus_pkg::data_t'(period_q);
    for (int c = 0; c < `SONATA_PWM_W; c++) begin
      if (duty_hit && duty_idx == (`SONATA_DEV_OFFS_W-2)'(c)) begin
        rdata_d = bus_pkg::data_t'(duty_q[c]);
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) rvalid_o <= 1'b0;
    else       rvalid_o <= req_i;
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && op_i == bus_pkg::OP_READ) rdata_o <= rdata_d;
  end

endmodule

/* logic/timer_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Machine timer
// Free-running 64-bit mtime with compare and timer interrupt
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sonata_cfg.svh"

module timer_regs (
  input  logic              clk_sys_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  bus_pkg::bus_op_e  op_i,
  input  bus_pkg::offs_t    offs_i,
  input  bus_pkg::be_t      be_i,
  input  bus_pkg::data_t    wdata_i,
  output logic              rvalid_o,
  output bus_pkg::data_t    rdata_o,
  output logic              timer_irq_o
);

  localparam int W = `SONATA_BUS_DATA_W;

  periph_pkg::time_t      mtime_q;
  periph_pkg::time_t      mtimecmp_q;
  periph_pkg::timer_reg_e reg_sel;
  logic                   reg_hit;
  logic                   wr_en;
  bus_pkg::data_t         wmask;
  bus_pkg::data_t         rdata_d;

  // Keep the old bits of disabled lanes
  function automatic bus_pkg::data_t merge(bus_pkg::data_t old_val, bus_pkg::data_t mask,
                                           bus_pkg::data_t new_val);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  always_comb begin
    reg_hit = 1'b1;
    reg_sel = periph_pkg::TMR_MTIME_LO;
    case (offs_i)
      `SONATA_TIMER_MTIME_LO_OFFS:    reg_sel = periph_pkg::TMR_MTIME_LO;
      `SONATA_TIMER_MTIME_HI_OFFS:    reg_sel = periph_pkg::TMR_MTIME_HI;
      `SONATA_TIMER_MTIMECMP_LO_OFFS: reg_sel = periph_pkg::TMR_MTIMECMP_LO;
      `SONATA_TIMER_MTIMECMP_HI_OFFS: reg_sel = periph_pkg::TMR_MTIMECMP_HI;
      default:                        reg_hit = 1'b0;
    endcase
    for (int b = 0; b < `SONATA_BUS_BE_W; b++) wmask[b*8 +: 8] = {8{be_i[b]}};
  end

  assign wr_en = req_i && op_i == bus_pkg::OP_WRITE && reg_hit;

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      // A written cycle does not count
      if (wr_en && reg_sel == periph_pkg::TMR_MTIME_LO) begin
        mtime_q[W-1:0] <= merge(mtime_q[W-1:0], wmask, wdata_i);
      end else if (wr_en && reg_sel == periph_pkg::TMR_MTIME_HI) begin
        mtime_q[2*W-1:W] <= merge(mtime_q[2*W-1:W], wmask, wdata_i);
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && reg_sel == periph_pkg::TMR_MTIMECMP_LO) begin
        mtimecmp_q[W-1:0] <= merge(mtimecmp_q[W-1:0], wmask, wdata_i);
      end
      if (wr_en && reg_sel == periph_pkg::TMR_MTIMECMP_HI) begin
        mtimecmp_q[2*W-1:W] <= merge(mtimecmp_q[2*W-1:W], wmask, wdata_i);
      end
    end
  end

  always_comb begin
    case (reg_sel)
      periph_pkg::TMR_MTIME_LO:    rdata_d = mtime_q[W-1:0];
      periph_pkg::TMR_MTIME_HI:    rdata_d = mtime_q[2*W-1:W];
      periph_pkg::TMR_MTIMECMP_LO: rdata_d = mtimecmp_q[W-1:0];
      default:                     rdata_d = mtimecmp_q[2*W-1:W];
    endcase
    if (!reg_hit) rdata_d = '0;
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) rvalid_o <= 1'b0;
    else       rvalid_o <= req_i;
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i && op_i == bus_pkg::OP_READ) rdata_o <= rdata_d;
  end

  assign timer_irq_o = mtime_q >= mtimecmp_q;   // Level, held until cmp moves

endmodule

/* logic/sonata_periph_top.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem top
// One register bus host port feeding GPIO, PWM and timer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sonata_periph_top (
  input  logic              clk_sys_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  bus_pkg::bus_op_e  op_i,
  input  bus_pkg::addr_t    addr_i,
  input  bus_pkg::be_t      be_i,
  input  bus_pkg::data_t    wdata_i,
  output logic              rvalid_o,
  output bus_pkg::data_t    rdata_o,
  output logic              err_o,
  input  periph_pkg::gpi_t  gp_i,
  output periph_pkg::gpo_t  gp_o,
  output periph_pkg::pwm_t  pwm_o,
  output logic              timer_irq_o
);

  // Shared request fields
  logic             gpio_req, pwm_req, timer_req;
  bus_pkg::bus_op_e dev_op;
  bus_pkg::offs_t   dev_offs;
  bus_pkg::be_t     dev_be;
  bus_pkg::data_t   dev_wdata;

  // Per-device responses
  logic             gpio_rvalid, pwm_rvalid, timer_rvalid;
  bus_pkg::data_t   gpio_rdata;
  bus_pkg::data_t   pwm_rdata;
  bus_pkg::data_t   timer_rdata;

  bus_xbar u_xbar (
    .clk_sys_i, .rst_i,
    .req_i, .op_i, .addr_i, .be_i, .wdata_i,
    .rvalid_o, .rdata_o, .err_o,
    .gpio_req_o    (gpio_req),
    .pwm_req_o     (pwm_req),
    .timer_req_o   (timer_req),
    .dev_op_o      (dev_op),
    .dev_offs_o    (dev_offs),
    .dev_be_o      (dev_be),
    .dev_wdata_o   (dev_wdata),
    .gpio_rvalid_i (gpio_rvalid),
    .gpio_rdata_i  (gpio_rdata),
    .pwm_rvalid_i  (pwm_rvalid),
    .pwm_rdata_i   (pwm_rdata),
    .timer_rvalid_i(timer_rvalid),
    .timer_rdata_i (timer_rdata)
  );

  gpio_regs u_gpio (
    .clk_sys_i, .rst_i,
    .req_i   (gpio_req),
    .op_i    (dev_op),
    .offs_i  (dev_offs),
    .be_i    (dev_be),
    .wdata_i (dev_wdata),
    .gp_i,
    .rvalid_o(gpio_rvalid),
    .rdata_o (gpio_rdata),
    .gp_o
  );

  pwm_regs u_pwm (
    .clk_sys_i, .rst_i,
    .req_i   (pwm_req),
    .op_i    (dev_op),
    .offs_i  (dev_offs),
    .be_i    (dev_be),
    .wdata_i (dev_wdata),
    .rvalid_o(pwm_rvalid),
    .rdata_o (pwm_rdata),
    .pwm_o
  );

  timer_regs u_timer (
    .clk_sys_i, .rst_i,
    .req_i   (timer_req),
    .op_i    (dev_op),
    .offs_i  (dev_offs),
    .be_i    (dev_be),
    .wdata_i (dev_wdata),
    .rvalid_o(timer_rvalid),
    .rdata_o (timer_rdata),
    .timer_irq_o
  );

endmodule

/* tests/tb_tasks.svh */
////////////////////////////////////////////////////////////////////////////
// Testbench tasks
// Bus accesses, compares and the directed tests
////////////////////////////////////////////////////////////////////////////
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam int unsigned    SEED      = 32'h4b14;
localparam int             NUM_TESTS = 6;
localparam bus_pkg::data_t GPO_MASK  = (1 << `SONATA_GPO_W) - 1;

localparam bus_pkg::addr_t GPIO_OUT   = `SONATA_GPIO_BASE + `SONATA_GPIO_OUT_OFFS;
localparam bus_pkg::addr_t GPIO_IN    = `SONATA_GPIO_BASE + `SONATA_GPIO_IN_OFFS;
localparam bus_pkg::addr_t PWM_PERIOD = `SONATA_PWM_BASE + `SONATA_PWM_PERIOD_OFFS;
localparam bus_pkg::addr_t PWM_DUTY0  = `SONATA_PWM_BASE + `SONATA_PWM_DUTY_OFFS;
localparam bus_pkg::addr_t MTIME_LO   = `SONATA_TIMER_BASE + `SONATA_TIMER_MTIME_LO_OFFS;
localparam bus_pkg::addr_t MTIME_HI   = `SONATA_TIMER_BASE + `SONATA_TIMER_MTIME_HI_OFFS;
localparam bus_pkg::addr_t CMP_LO     = `SONATA_TIMER_BASE + `SONATA_TIMER_MTIMECMP_LO_OFFS;
localparam bus_pkg::addr_t CMP_HI     = `SONATA_TIMER_BASE + `SONATA_TIMER_MTIMECMP_HI_OFFS;

task automatic check_data(input bus_pkg::data_t got, input bus_pkg::data_t exp,
                          input string what);
  if (got !== exp) begin
    $display("** Error @ %0t ns: %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
    errors++;
  end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("** Error @ %0t ns: %s: got %b, expected %b", $time, what, got, exp);
    errors++;
  end
endtask

task automatic report_test(input string name, input int errs_before);
  tests_run++;
  $display("Test %s done with %0d error(s)", name, errors - errs_before);
endtask

// Expected word after a write with byte enables
function automatic bus_pkg::data_t lane_merge(bus_pkg::data_t old_val,
                                              bus_pkg::data_t new_val, bus_pkg::be_t lanes);
  bus_pkg::data_t res;
  res = old_val;
  for (int b = 0; b < `SONATA_BUS_BE_W; b++) begin
    if (lanes[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
  end
  return res;
endfunction

////////////////////////////////////////////////////////////////////////////
// Bus accesses, response one cycle after the request

task automatic bus_write(input bus_pkg::addr_t a, input bus_pkg::data_t d,
                         input bus_pkg::be_t lanes, output logic rsp_err);
  @(posedge clk_sys);
  req   <= 1'b1;
  op    <= bus_pkg::OP_WRITE;
  addr  <= a;
  be    <= lanes;
  wdata <= d;
  @(posedge clk_sys);
  req <= 1'b0;
  @(negedge clk_sys);
  if (rvalid !== 1'b1) begin
    $display("Write to 0x%08h got no response one cycle later (time %0t ns)", a, $time);
    errors++;
  end
  check_data(rdata, '0, "write response data");
  rsp_err = err;
endtask

task automatic bus_read(input bus_pkg::addr_t a, output bus_pkg::data_t d,
                        output logic rsp_err);
  @(posedge clk_sys);
  req   <= 1'b1;
  op    <= bus_pkg::OP_READ;
  addr  <= a;
  be    <= '1;
  wdata <= '0;
  @(posedge clk_sys);
  req <= 1'b0;
  @(negedge clk_sys);
  if (rvalid !== 1'b1) begin
    $display("Read of 0x%08h got no response one cycle later (time %0t ns)", a, $time);
    errors++;
  end
  d       = rdata;
  rsp_err = err;
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic test_reset_values();
  int             errs_before;
  bus_pkg::data_t rd;
  logic           rsp_err;
  errs_before = errors;
  @(negedge clk_sys);
  check_data(bus_pkg::data_t'(gp_out), '0, "gp_o after reset");
  check_data(bus_pkg::data_t'(pwm), '0, "pwm_o after reset");
  check_bit(timer_irq, 1'b0, "timer_irq_o after reset");
  bus_read(PWM_PERIOD, rd, rsp_err);
  check_data(rd, 32'hFF, "PWM period after reset");
  check_bit(rsp_err, 1'b0, "err on PERIOD read");
  report_test("reset_values", errs_before);
endtask

task automatic test_gpio();
  int               errs_before;
  bus_pkg::data_t   w;
  bus_pkg::data_t   exp;
  bus_pkg::data_t   rd;
  logic             rsp_err;
  periph_pkg::gpi_t g;
  errs_before = errors;
  for (int i = 0; i < 4; i++) begin
    w = $urandom;
    bus_write(GPIO_OUT, w, 4'hF, rsp_err);
    bus_read(GPIO_OUT, rd, rsp_err);
    check_data(rd, w & GPO_MASK, "GPIO OUT readback");
    check_data(bus_pkg::data_t'(gp_out), w & GPO_MASK, "gp_o after full write");
  end
  exp = 32'h00C3_5AA5;
  bus_write(GPIO_OUT, exp, 4'hF, rsp_err);
  w = $urandom;
  bus_write(GPIO_OUT, w, 4'b0101, rsp_err);   // Lanes 0 and 2 only
  exp = lane_merge(exp, w, 4'b0101) & GPO_MASK;
  bus_read(GPIO_OUT, rd, rsp_err);
  check_data(rd, exp, "GPIO OUT after lanes 0,2");
  w = $urandom;
  bus_write(GPIO_OUT, w, 4'b0010, rsp_err);
  exp = lane_merge(exp, w, 4'b0010) & GPO_MASK;
  check_data(bus_pkg::data_t'(gp_out), exp, "gp_o after lane 1");
  // Inputs pass two sync flops
  g = periph_pkg::gpi_t'($urandom);
  @(posedge clk_sys);
  gp_in <= g;
  repeat (3) @(posedge clk_sys);
  bus_read(GPIO_IN, rd, rsp_err);
  check_data(rd, bus_pkg::data_t'(g), "GPIO IN");
  report_test("gpio", errs_before);
endtask

task automatic test_decode_errors();
  int               errs_before;
  bus_pkg::addr_t   bad [3];
  bus_pkg::data_t   rd;
  logic             rsp_err;
  periph_pkg::gpo_t hold;
  errs_before = errors;
  bad  = '{32'h8000_3000, 32'h0000_0000, 32'hFFFF_FFFC};
  hold = gp_out;
  for (int i = 0; i < 3; i++) begin
    bus_read(bad[i], rd, rsp_err);
    check_bit(rsp_err, 1'b1, "err on unmapped read");
    check_data(rd, '0, "rdata on unmapped read");
    bus_write(bad[i], $urandom, 4'hF, rsp_err);
    check_bit(rsp_err, 1'b1, "err on unmapped write");
  end
  check_data(bus_pkg::data_t'(gp_out), bus_pkg::data_t'(hold), "gp_o after bad writes");
  bus_read(GPIO_OUT, rd, rsp_err);
  check_bit(rsp_err, 1'b0, "err on GPIO read after errors");
  check_data(rd, bus_pkg::data_t'(hold), "GPIO OUT after errors");
  bus_read(PWM_PERIOD, rd, rsp_err);
  check_bit(rsp_err, 1'b0, "err on PWM read after errors");
  report_test("decode_errors", errs_before);
endtask

task automatic test_pwm();
  int             errs_before;
  int             cnt [3];
  int             period;
  int             duty;
  logic           others;
  bus_pkg::data_t rd;
  logic           rsp_err;
  errs_before = errors;
  period = 20;
  duty   = 7;
  cnt    = '{0, 0, 0};
  others = 1'b0;
  bus_write(PWM_PERIOD, period, 4'hF, rsp_err);
  bus_write(PWM_DUTY0, 0, 4'hF, rsp_err);
  bus_write(PWM_DUTY0 + 4, duty, 4'hF, rsp_err);
  bus_write(PWM_DUTY0 + 8, period + 1, 4'hF, rsp_err);
  bus_read(PWM_DUTY0 + 4, rd, rsp_err);
  check_data(rd, duty, "PWM duty 1 readback");
  bus_read(PWM_PERIOD, rd, rsp_err);
  check_data(rd, period, "PWM period readback");
  // One full PWM cycle
  for (int n = 0; n <= period; n++) begin
    @(negedge clk_sys);
    for (int c = 0; c < 3; c++) begin
      if (pwm[c]) cnt[c]++;
    end
    others = others | (|pwm[`SONATA_PWM_W-1:3]);
  end
  check_data(cnt[0], 0, "high cycles, duty 0");
  check_data(cnt[1], duty, "high cycles, duty D");
  check_data(cnt[2], period + 1, "high cycles, duty P+1");
  check_bit(others, 1'b0, "unused channels high");
  report_test("pwm", errs_before);
endtask

task automatic test_timer();
  int             errs_before;
  int             waited;
  bus_pkg::data_t first;
  bus_pkg::data_t second;
  logic           rsp_err;
  errs_before = errors;
  bus_write(CMP_LO, 32'h0, 4'hF, rsp_err);
  bus_write(CMP_HI, 32'h8000_0000, 4'hF, rsp_err);   // Far ahead
  repeat (16) begin
    @(negedge clk_sys);
    check_bit(timer_irq, 1'b0, "irq with distant compare");
  end
  bus_read(MTIME_LO, first, rsp_err);
  bus_read(MTIME_LO, second, rsp_err);
  check_bit(second > first, 1'b1, "mtime advances between reads");
  bus_write(MTIME_HI, 32'h0, 4'hF, rsp_err);
  bus_write(MTIME_LO, 32'd100, 4'hF, rsp_err);
  bus_write(CMP_LO, 32'd112, 4'hF, rsp_err);
  bus_write(CMP_HI, 32'h0, 4'hF, rsp_err);
  check_bit(timer_irq, 1'b0, "irq just before compare");
  waited = 0;
  while (timer_irq !== 1'b1 && waited < 20) begin
    @(negedge clk_sys);
    waited++;
  end
  if (timer_irq !== 1'b1) begin
    $display("Timer interrupt did not rise within 20 cycles of the compare write");
    errors++;
  end
  repeat (10) begin
    @(negedge clk_sys);
    check_bit(timer_irq, 1'b1, "irq held after compare");
  end
  report_test("timer", errs_before);
endtask

task automatic test_back_to_back();
  int             errs_before;
  bus_pkg::data_t w;
  errs_before = errors;
  w = $urandom;
  @(posedge clk_sys);
  req   <= 1'b1;
  op    <= bus_pkg::OP_WRITE;
  addr  <= GPIO_OUT;
  be    <= 4'hF;
  wdata <= w;
  @(posedge clk_sys);
  op    <= bus_pkg::OP_READ;   // Read follows in the next cycle
  wdata <= '0;
  @(negedge clk_sys);
  check_bit(rvalid, 1'b1, "rvalid for write");
  check_bit(err, 1'b0, "err for write");
  check_data(rdata, '0, "rdata for write");
  @(posedge clk_sys);
  req <= 1'b0;
  @(negedge clk_sys);
  check_bit(rvalid, 1'b1, "rvalid for read");
  check_data(rdata, w & GPO_MASK, "read right after write");
  report_test("back_to_back", errs_before);
endtask

`endif

/* tests/tb_sonata.sv */
////////////////////////////////////////////////////////////////////////////
// Peripheral subsystem testbench
// Clock, reset, DUT, watchdog and the directed test sequence
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "sonata_cfg.svh"

module tb_sonata;

  localparam int CLK_PERIOD = 40;

  logic              clk_sys;
  logic              rst;
  // Host port
  logic              req;
  bus_pkg::bus_op_e  op;
  bus_pkg::addr_t    addr;
  bus_pkg::be_t      be;
  bus_pkg::data_t    wdata;
  logic              rvalid;
  bus_pkg::data_t    rdata;
  logic              err;
  // Pins
  periph_pkg::gpi_t  gp_in;
  periph_pkg::gpo_t  gp_out;
  periph_pkg::pwm_t  pwm;
  logic              timer_irq;

  int errors;
  int tests_run;

  `include "tb_tasks.svh"

  sonata_periph_top u_sonata_periph_top (
    .clk_sys_i  (clk_sys),
    .rst_i      (rst),
    .req_i      (req),
    .op_i       (op),
    .addr_i     (addr),
    .be_i       (be),
    .wdata_i    (wdata),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata),
    .err_o      (err),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .pwm_o      (pwm),
    .timer_irq_o(timer_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
  end

  // Watchdog, 2000 cycles per test
  initial begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("Watchdog timeout: the test sequence did not complete in time");
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    errors    = 0;
    tests_run = 0;
    rst       = 1'b1;
    req       = 1'b0;
    op        = bus_pkg::OP_READ;
    addr      = '0;
    be        = '0;
    wdata     = '0;
    gp_in     = '0;
    void'($urandom(SEED));

    repeat (8) @(posedge clk_sys);
    rst <= 1'b0;

    test_reset_values();
    test_gpio();
    test_decode_errors();
    test_pwm();
    test_timer();
    test_back_to_back();

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+logic
+incdir+tests
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/bus_xbar.sv
logic/gpio_regs.sv
logic/pwm_regs.sv
logic/timer_regs.sv
logic/sonata_periph_top.sv
tests/tb_sonata.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_sonata \
  --Mdir obj_dir -o Vtb_sonata
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sonata > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
